// File: flist.f
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_decode.sv
hdl/operand_read.sv
hdl/alu_exec.sv
hdl/rv_core.sv
testbench/rv_core_checker.sv
testbench/tb_scoreboard.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_top.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_top;
    import pipe_pkg::*;
    import isa_pkg::*;

    localparam int PROG_LEN  = 400;
    localparam int CYC_LIMIT = PROG_LEN + 60;
    localparam int RST_CYC   = 10;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] imem_addr;
    insn_u            imem_insn;
    wb_res_t          retire;

    logic [31:0] prog [PROG_LEN];
    integer      seed;
    int          legal_cnt;
    int          retired_cnt;
    int          err_cnt;
    int          cycles;

    rv_core UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_insn (imem_insn),
        .retire    (retire)
    );

    tb_scoreboard #(.PROG_LEN(PROG_LEN)) u_scoreboard (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .retire      (retire),
        .prog        (prog),
        .retired_cnt (retired_cnt),
        .err_cnt     (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Memory model, words past the program are illegal
    always @(posedge clk) begin
        #2;
        if (imem_addr < 4 * PROG_LEN) begin
            imem_insn <= prog[imem_addr[31:2]];
        end else begin
            imem_insn <= {imem_addr[31:7] ^ {18'b0, imem_addr[6:0]}, 7'h7f};
        end
    end

    function automatic int unsigned rnd_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic build_program();
        int unsigned kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = rnd_below(100);
            f3   = 3'(rnd_below(8));
            rd   = 5'(rnd_below(8));  // Small register set for dense hazards
            rs1  = 5'(rnd_below(8));
            rs2  = 5'(rnd_below(8));
            imm  = 12'($random(seed));
            f7   = rnd_below(2) ? `F7_ALT : `F7_BASE;
            if (kind < 5 && i != 0) begin
                prog[i] = {$random(seed)};
                prog[i][6:0] = 7'b1100011;
            end else if (kind < 20) begin
                prog[i] = {imm, rs1, f3, rd, `OPC_LUI};
            end else if (kind < 60) begin
                if (f3 == `F3_SLL) begin
                    imm[11:5] = `F7_BASE;
                end else if (f3 == `F3_SR) begin
                    imm[11:5] = f7;
                end
                prog[i] = {imm, rs1, f3, rd, `OPC_OP_IMM};
            end else begin
                if (f3 != `F3_ADD && f3 != `F3_SR) begin
                    f7 = `F7_BASE;
                end
                prog[i] = {f7, rs2, rs1, f3, rd, `OPC_OP};
            end
            if (prog[i][6:0] != 7'b1100011) begin
                legal_cnt++;
            end
        end
    endtask

    initial begin
        seed      = 32'hae09c726;
        rst_n     = 1'b0;
        imem_insn = '0;
        cycles    = 0;
        legal_cnt = 0;
        build_program();
        repeat (RST_CYC) @(posedge clk);
        #2 rst_n = 1'b1;

        while (retired_cnt < legal_cnt && cycles < CYC_LIMIT) begin
            @(posedge clk);
        end
        if (cycles >= CYC_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, retired_cnt, legal_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            repeat (6) @(posedge clk);  // Catch any stray retirement
            u_scoreboard.report(legal_cnt);
            #1;
            if (err_cnt == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: testbench/tb_scoreboard.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_scoreboard #(
    parameter int PROG_LEN = 400
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`XLEN-1:0]  imem_addr,
    input  pipe_pkg::wb_res_t retire,
    input  logic [31:0]       prog [PROG_LEN],
    output int                retired_cnt,
    output int                err_cnt
);

    localparam int N_TESTS = 6;

    logic [`XLEN-1:0] regs [32];
    int               last_wr [32];  // Sequence number of last writer
    int               pass_cnt [N_TESTS];
    int               fail_cnt [N_TESTS];
    int               prog_idx;
    int               skipped;
    int               cyc;
    string            names [N_TESTS] = '{"reset timing", "OP-IMM", "OP",
                                          "dependencies", "LUI and x0", "illegal words"};

    function automatic bit is_legal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            `OPC_LUI:    return 1'b1;
            `OPC_OP_IMM: begin
                if (f3 == 3'b001) return f7 == 7'h00;
                if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
                return 1'b1;
            end
            `OPC_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            default:     return 1'b0;
        endcase
    endfunction

    // Reference result straight from the ISA rules
    function automatic logic [31:0] model_exec(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        alt;
        if (w[6:0] == `OPC_LUI) return {w[31:12], 12'b0};
        a   = regs[w[19:15]];
        b   = (w[6:0] == `OPC_OP) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh  = b[4:0];
        alt = w[30];
        case (w[14:12])
            3'b000:  return (w[6:0] == `OPC_OP && alt) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic int category(input logic [31:0] w, input int seq);
        bit uses_rs2;
        uses_rs2 = (w[6:0] == `OPC_OP);
        if (w[6:0] == `OPC_LUI || w[11:7] == 0) return 4;
        if (w[19:15] != 0 && seq - last_wr[w[19:15]] <= 3) return 3;
        if (uses_rs2 && w[24:20] != 0 && seq - last_wr[w[24:20]] <= 3) return 3;
        return uses_rs2 ? 2 : 1;
    endfunction

    task automatic tally(input int t, input bit ok);
        if (ok) begin
            pass_cnt[t]++;
        end else begin
            fail_cnt[t]++;
            err_cnt++;
        end
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i]    = '0;
            last_wr[i] = -100;
        end
        for (int t = 0; t < N_TESTS; t++) begin
            pass_cnt[t] = 0;
            fail_cnt[t] = 0;
        end
        retired_cnt = 0;
        err_cnt     = 0;
        prog_idx    = 0;
        skipped     = 0;
    end

    always @(posedge clk) begin
        cyc <= rst_n ? cyc + 1 : 0;
    end

    ////////////////////////////////////////
    // Compare on the falling edge
    ////////////////////////////////////////

    always @(negedge clk) begin
        logic [31:0] w;
        logic [31:0] exp;
        int          t;
        if (rst_n) begin
            if (imem_addr !== 32'(cyc * 4)) begin
                $display("ERR %0t imem_addr expected=%h actual=%h", $time, cyc * 4, imem_addr);
                tally(0, 1'b0);
            end
            if (retire.valid === 1'b1) begin
                if (retired_cnt == 0) begin
                    if (cyc != 3) begin
                        $display("First retirement came %0d cycles after reset, not 3", cyc);
                    end
                    tally(0, cyc == 3);
                end
                while (prog_idx < PROG_LEN && !is_legal(prog[prog_idx])) begin
                    prog_idx++;
                    skipped++;
                end
                if (prog_idx >= PROG_LEN) begin
                    $display("Retirement at %0t with no legal instruction left", $time);
                    tally(5, 1'b0);
                end else begin
                    w   = prog[prog_idx];
                    exp = model_exec(w);
                    t   = category(w, retired_cnt);
                    if (retire.rd !== w[11:7]) begin
                        $display("ERR %0t retire.rd expected=%0d actual=%0d",
                                 $time, w[11:7], retire.rd);
                        tally(t, 1'b0);
                    end else if (retire.data !== exp) begin
                        $display("ERR %0t retire.data expected=%h actual=%h",
                                 $time, exp, retire.data);
                        tally(t, 1'b0);
                    end else begin
                        tally(t, 1'b1);
                    end
                    if (w[11:7] != 0) begin
                        regs[w[11:7]]    = exp;
                        last_wr[w[11:7]] = retired_cnt;
                    end
                    prog_idx++;
                end
                retired_cnt++;
            end else if (retire.valid !== 1'b0) begin
                $display("retire.valid is unknown at %0t", $time);
                tally(0, 1'b0);
            end
        end
    end

    task automatic report(input int legal_cnt);
        tally(5, retired_cnt == legal_cnt);
        if (retired_cnt != legal_cnt) begin
            $display("Retired %0d instructions, program has %0d legal words",
                     retired_cnt, legal_cnt);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            $display("%-14s %0d ok, %0d bad", names[t], pass_cnt[t], fail_cnt[t]);
        end
        $display("Retired %0d, skipped %0d illegal, %0d errors",
                 retired_cnt, skipped, err_cnt);
    endtask

endmodule

// File: testbench/rv_core_checker.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_checker (
    input logic             clk,
    input logic             rst_n,
    input logic [`XLEN-1:0] imem_addr,
    input logic             retire_valid
);

    // Quiet during reset and while the pipe fills
    a_no_early_retire: assert property (@(posedge clk)
        (!$past(rst_n, 1) || !$past(rst_n, 2) || !$past(rst_n, 3))
        |-> !retire_valid)
        else $error("retire.valid high too close to reset");

    a_pc_step: assert property (@(posedge clk)
        (rst_n && $past(rst_n)) |-> imem_addr == $past(imem_addr) + 32'd4)
        else $error("imem_addr did not step by 4");

    a_pc_start: assert property (@(posedge clk)
        (rst_n && !$past(rst_n)) |-> imem_addr == '0)
        else $error("imem_addr not 0 after reset");

endmodule

bind rv_core rv_core_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_addr    (imem_addr),
    .retire_valid (retire.valid)
);

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core (
    input  logic              clk,
    input  logic              rst_n,
    output logic [`XLEN-1:0]  imem_addr,
    input  isa_pkg::insn_u    imem_insn,
    output pipe_pkg::wb_res_t retire
);
    import pipe_pkg::*;

    dec_insn_t dec;
    ex_ops_t   ex_ops;
    wb_res_t   ex_fwd;

    // Fetch and decode
    fetch_decode u_fetch_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_insn (imem_insn),
        .dec       (dec)
    );

    operand_read u_operand_read (
        .clk    (clk),
        .rst_n  (rst_n),
        .dec    (dec),
        .ex_fwd (ex_fwd),
        .retire (retire),  // Also the register-file write port
        .ex_ops (ex_ops)
    );

    alu_exec u_alu_exec (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_ops (ex_ops),
        .ex_fwd (ex_fwd),
        .retire (retire)
    );

endmodule

// File: hdl/alu_exec.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module alu_exec (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::ex_ops_t ex_ops,
    output pipe_pkg::wb_res_t ex_fwd,
    output pipe_pkg::wb_res_t retire
);
    import pipe_pkg::*;

    logic [`XLEN-1:0]    result;
    logic [`SHAMT_W-1:0] shamt;
    logic                lt_signed;
    logic                lt_unsigned;

    assign shamt       = ex_ops.b[`SHAMT_W-1:0];
    assign lt_signed   = $signed(ex_ops.a) < $signed(ex_ops.b);
    assign lt_unsigned = ex_ops.a < ex_ops.b;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (ex_ops.alu_op)
            ALU_ADD:    result = ex_ops.a + ex_ops.b;
            ALU_SUB:    result = ex_ops.a - ex_ops.b;
            ALU_SLL:    result = ex_ops.a << shamt;
            ALU_SLT:    result = `XLEN'(lt_signed);
            ALU_SLTU:   result = `XLEN'(lt_unsigned);
            ALU_XOR:    result = ex_ops.a ^ ex_ops.b;
            ALU_SRL:    result = ex_ops.a >> shamt;
            ALU_SRA:    result = $signed(ex_ops.a) >>> shamt;  // Sign fill
            ALU_OR:     result = ex_ops.a | ex_ops.b;
            ALU_AND:    result = ex_ops.a & ex_ops.b;
            ALU_PASS_B: result = ex_ops.b;
            default:    result = '0;
        endcase
    end

    // Same-cycle result for the forwarding path
    always_comb begin
        ex_fwd.valid = ex_ops.valid;
        ex_fwd.rd    = ex_ops.rd;
        ex_fwd.data  = result;
    end

    ////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        retire <= ex_fwd;
        if (!rst_n) begin
            retire.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/operand_read.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module operand_read (
    input  logic                clk,
    input  logic                rst_n,
    input  pipe_pkg::dec_insn_t dec,
    input  pipe_pkg::wb_res_t   ex_fwd,
    input  pipe_pkg::wb_res_t   retire,
    output pipe_pkg::ex_ops_t   ex_ops
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    ex_ops_t          ex_d;

    // Nearest producer wins
    function automatic logic [`XLEN-1:0] pick_src(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`XLEN-1:0]       rf_val,
        input wb_res_t                ex_r,
        input wb_res_t                wb_r
    );
        logic [`XLEN-1:0] val;
        if (src == '0) begin
            val = '0;
        end else if (ex_r.valid && ex_r.rd == src) begin
            val = ex_r.data;
        end else if (wb_r.valid && wb_r.rd == src) begin
            val = wb_r.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != '0) begin
            regs[retire.rd] <= retire.data;
        end
    end

    assign src_a = pick_src(dec.rs1, regs[dec.rs1], ex_fwd, retire);
    assign src_b = pick_src(dec.rs2, regs[dec.rs2], ex_fwd, retire);

    always_comb begin
        ex_d.valid  = dec.valid;
        ex_d.alu_op = dec.alu_op;
        ex_d.rd     = dec.rd;
        ex_d.a      = src_a;
        ex_d.b      = dec.use_imm ? dec.imm : src_b;
    end

    always_ff @(posedge clk) begin
        ex_ops <= ex_d;
        if (!rst_n) begin
            ex_ops.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/fetch_decode.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module fetch_decode (
    input  logic                clk,
    input  logic                rst_n,
    output logic [`XLEN-1:0]    imem_addr,
    input  isa_pkg::insn_u      imem_insn,
    output pipe_pkg::dec_insn_t dec
);
    import pipe_pkg::*;

    logic [`XLEN-1:0] pc;
    logic             is_op;
    logic             is_shift;
    logic             f7_alt;
    logic             alt_allowed;
    logic             f7_legal;
    alu_op_e          f3_op;
    dec_insn_t        dec_d;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc + `XLEN'd4;  // No branches, straight line only
        end
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign is_op       = (imem_insn.r.opcode == `OPC_OP);
    assign is_shift    = (imem_insn.r.funct3 == `F3_SLL) || (imem_insn.r.funct3 == `F3_SR);
    assign f7_alt      = (imem_insn.r.funct7 == `F7_ALT);
    assign alt_allowed = (imem_insn.r.funct3 == `F3_SR) ||
                         (is_op && imem_insn.r.funct3 == `F3_ADD);
    assign f7_legal    = (imem_insn.r.funct7 == `F7_BASE) || (f7_alt && alt_allowed);

    always_comb begin
        case (imem_insn.r.funct3)
            `F3_ADD:  f3_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
            `F3_SLL:  f3_op = ALU_SLL;
            `F3_SLT:  f3_op = ALU_SLT;
            `F3_SLTU: f3_op = ALU_SLTU;
            `F3_XOR:  f3_op = ALU_XOR;
            `F3_SR:   f3_op = f7_alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   f3_op = ALU_OR;
            default:  f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_d        = '0;
        dec_d.rd     = imem_insn.r.rd;
        dec_d.rs1    = imem_insn.r.rs1;
        dec_d.rs2    = imem_insn.r.rs2;
        dec_d.alu_op = f3_op;
        dec_d.imm    = {{(`XLEN-12){imem_insn.i.imm12[11]}}, imem_insn.i.imm12};
        case (imem_insn.r.opcode)
            `OPC_OP_IMM: begin
                dec_d.valid   = is_shift ? f7_legal : 1'b1;  // Shift imm[11:5] is funct7
                dec_d.use_imm = 1'b1;
            end
            `OPC_OP: begin
                dec_d.valid = f7_legal;
            end
            `OPC_LUI: begin
                dec_d.valid   = 1'b1;
                dec_d.use_imm = 1'b1;
                dec_d.alu_op  = ALU_PASS_B;
                dec_d.imm     = {imem_insn.i.imm12, imem_insn.i.rs1, imem_insn.i.funct3, 12'b0};
            end
            default: begin
                dec_d.valid = 1'b0;  // Dropped as a bubble
            end
        endcase
    end

    always_ff @(posedge clk) begin
        dec <= dec_d;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/pipe_pkg.sv
`include "rv_consts.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B  // LUI
    } alu_op_e;

    // Decode -> operand read
    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        logic                   use_imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
    } dec_insn_t;

    // Operand read -> execute
    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
    } ex_ops_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_res_t;

endpackage

// File: hdl/isa_pkg.sv
`include "rv_consts.svh"

package isa_pkg;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    // Same 32-bit word, decoded as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } insn_u;

endpackage

// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define NUM_REGS   32
`define SHAMT_W    5

// Major opcodes kept by the core
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LUI    7'b0110111

// funct3 codes
`define F3_ADD     3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SR      3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

`define F7_BASE    7'b0000000
`define F7_ALT     7'b0100000  // SUB, SRA, SRAI

`endif
